//--- bench/rasTests.dat
# bundleIp, then per slot: queued jal call ret ra rd seqNum, then expected retAddr
# addresses in hex, slot columns in decimal, three slot groups in order 0 1 2
00001000  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0 0 0 0   FFFFFC00
00001000  1 0 1 0 0 0 1   0 0 0 0 0 0 0   0 0 0 0 0 0 0   00001005
00002000  0 0 0 0 0 0 0   1 0 1 0 0 0 2   0 0 0 0 0 0 0   0000200A
00003000  0 0 0 0 0 0 0   0 0 0 0 0 0 0   1 1 0 0 0 61 3  00003010
00004000  1 0 0 1 0 0 4   0 0 0 0 0 0 0   0 0 0 0 0 0 0   0000200A
00005000  0 0 0 0 0 0 0   1 1 0 0 61 0 5  0 0 0 0 0 0 0   00001005
00006000  0 0 0 0 0 0 0   0 0 0 0 0 0 0   1 0 0 1 0 0 6   FFFFFC00
00007000  1 1 0 0 61 61 7 0 0 0 0 0 0 0   0 0 0 0 0 0 0   00007005
00008000  1 0 1 0 0 0 8   1 0 0 1 0 0 8   1 0 1 0 0 0 8   00008005
00009000  0 0 1 0 0 0 9   1 0 0 1 0 0 9   1 0 1 0 0 0 9   00007005
0000A000  1 0 1 0 0 0 8   1 0 1 0 0 0 11  1 0 0 1 0 0 11  00007005
0000B000  0 0 0 0 0 0 0   1 0 1 0 0 0 12  0 0 0 0 0 0 0   0000B00A
0000B000  0 0 0 0 0 0 0   1 0 1 0 0 0 12  0 0 0 0 0 0 0   0000B00A
0000C000  0 0 0 0 0 0 0   1 0 1 0 0 0 13  0 0 0 0 0 0 0   0000C00A
0000D000  1 1 0 0 2 1 14  1 0 0 0 0 0 14  1 0 0 0 0 0 14  0000C00A
0000E000  0 0 1 0 0 0 15  0 0 0 1 0 0 15  0 1 0 0 0 61 15 0000C00A
0000F000  1 0 0 1 0 0 16  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0000B00A
0000F000  1 0 0 1 0 0 16  0 0 0 0 0 0 0   0 0 0 0 0 0 0   0000B00A
0000F000  1 0 0 1 0 0 17  0 0 0 0 0 0 0   0 0 0 0 0 0 0   00007005
0000F000  0 0 0 0 0 0 0   0 0 0 0 0 0 0   1 0 0 1 0 0 18  FFFFFC00
00100010  1 0 1 0 0 0 20  0 0 0 0 0 0 0   0 0 0 0 0 0 0   00100015
00100020  1 0 1 0 0 0 21  0 0 0 0 0 0 0   0 0 0 0 0 0 0   00100025
00100030  1 0 1 0 0 0 22  0 0 0 0 0 0 0   0 0 0 0 0 0 0   00100035
00100040  1 0 1 0 0 0 23  0 0 0 0 0 0 0   0 0 0 0 0 0 0   00100045
00100050  1 0 1 0 0 0 24  0 0 0 0 0 0 0   0 0 0 0 0 0 0   00100055
00100060  1 0 1 0 0 0 25  0 0 0 0 0 0 0   0 0 0 0 0 0 0   00100065
00100070  1 0 1 0 0 0 26  0 0 0 0 0 0 0   0 0 0 0 0 0 0   00100075
00100080  1 0 1 0 0 0 27  0 0 0 0 0 0 0   0 0 0 0 0 0 0   00100085
00100090  1 0 1 0 0 0 28  0 0 0 0 0 0 0   0 0 0 0 0 0 0   00100095
001000A0  1 0 1 0 0 0 29  0 0 0 0 0 0 0   0 0 0 0 0 0 0   001000A5
001000B0  1 0 1 0 0 0 30  0 0 0 0 0 0 0   0 0 0 0 0 0 0   001000B5
001000C0  1 0 1 0 0 0 31  0 0 0 0 0 0 0   0 0 0 0 0 0 0   001000C5
001000D0  1 0 1 0 0 0 0   0 0 0 0 0 0 0   0 0 0 0 0 0 0   001000D5
001000E0  1 0 1 0 0 0 1   0 0 0 0 0 0 0   0 0 0 0 0 0 0   001000E5
001000F0  1 0 1 0 0 0 2   0 0 0 0 0 0 0   0 0 0 0 0 0 0   001000F5
00100100  1 0 1 0 0 0 3   0 0 0 0 0 0 0   0 0 0 0 0 0 0   00100105
00100110  1 0 1 0 0 0 4   0 0 0 0 0 0 0   0 0 0 0 0 0 0   00100115
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 14  0 0 0 0 0 0 0   00100105
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 15  0 0 0 0 0 0 0   001000F5
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 16  0 0 0 0 0 0 0   001000E5
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 17  0 0 0 0 0 0 0   001000D5
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 18  0 0 0 0 0 0 0   001000C5
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 19  0 0 0 0 0 0 0   001000B5
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 20  0 0 0 0 0 0 0   001000A5
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 21  0 0 0 0 0 0 0   00100095
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 22  0 0 0 0 0 0 0   00100085
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 23  0 0 0 0 0 0 0   00100075
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 24  0 0 0 0 0 0 0   00100065
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 25  0 0 0 0 0 0 0   00100055
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 26  0 0 0 0 0 0 0   00100045
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 27  0 0 0 0 0 0 0   00100035
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 28  0 0 0 0 0 0 0   00100025
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 29  0 0 0 0 0 0 0   00100115
00200000  0 0 0 0 0 0 0   1 0 0 1 0 0 30  0 0 0 0 0 0 0   00100105

//--- bench/retPredictTb.sv
// ======================================================================
// testbench for the return address predictor
// each line of bench/rasTests.dat is held for one bundle period and
// retAddr is checked in the idle cycle, the run stops at the first error
// ======================================================================

module retPredictTb import rasPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// ==================================================================
	// DUT signals and test storage
	// ==================================================================

	logic clk4x;
	logic rst;
	addrT bundleIp;
	slotInT slot0;
	slotInT slot1;
	slotInT slot2;
	addrT retAddr;

	// one entry per data line, in file order
	addrT ipList[$];
	slotInT s0List[$];
	slotInT s1List[$];
	slotInT s2List[$];
	addrT expList[$];
	int lineList[$];

	int nLines;
	bit loaded = 1'b0;

	retPredictTop u_dut (
		.clk4x(clk4x),
		.rst(rst),
		.bundleIp(bundleIp),
		.slot0(slot0),
		.slot1(slot1),
		.slot2(slot2),
		.retAddr(retAddr)
	);

	// 4 ns clk4x, so one bundle period is 16 ns
	initial begin
		clk4x = 1'b0;
		forever #2 clk4x = ~clk4x;
	end

	// ==================================================================
	// reading the data file
	// ==================================================================

	// build one slot from its decimal columns
	function automatic slotInT makeSlot(input logic [31:0] q, input logic [31:0] j,
		input logic [31:0] c, input logic [31:0] r, input logic [31:0] ra,
		input logic [31:0] rd, input logic [31:0] sq);
		slotInT s;
		s.queued = q[0];
		s.jal = j[0];
		s.call = c[0];
		s.ret = r[0];
		s.ra = ra[5:0];
		s.rd = rd[5:0];
		s.seqNum = sq[4:0];
		return s;
	endfunction

	task automatic loadTests();
		int fd;
		int code;
		int lineNo;
		logic [31:0] fld [23];
		string lineText;
		fd = $fopen("bench/rasTests.dat", "r");
		if (fd == 0) begin
			$display("cannot open the test data file bench/rasTests.dat");
			$display("RESULT: FAIL");
			$fatal(1, "test data file missing");
		end
		lineNo = 0;
		while ($fgets(lineText, fd) != 0) begin
			lineNo++;
			// comment lines and blank lines carry no bundle
			if (lineText.len() < 3 || lineText.getc(0) == "#") begin
				continue;
			end
			code = $sscanf(lineText,
				"%h %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %h",
				fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
				fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
				fld[15], fld[16], fld[17], fld[18], fld[19], fld[20], fld[21],
				fld[22]);
			if (code != 23) begin
				$display("line %0d of the test data file has the wrong number of columns",
					lineNo);
				$display("RESULT: FAIL");
				$fatal(1, "bad test data line");
			end
			ipList.push_back(fld[0]);
			s0List.push_back(makeSlot(fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7]));
			s1List.push_back(makeSlot(fld[8], fld[9], fld[10], fld[11], fld[12], fld[13],
				fld[14]));
			s2List.push_back(makeSlot(fld[15], fld[16], fld[17], fld[18], fld[19], fld[20],
				fld[21]));
			expList.push_back(fld[22]);
			lineList.push_back(lineNo);
		end
		$fclose(fd);
		nLines = ipList.size();
	endtask

	// ==================================================================
	// driving and checking
	// ==================================================================

	// called on a falling edge just before a slot 0 cycle
	task automatic applyLine(input int i);
		bundleIp = ipList[i];
		slot0 = s0List[i];
		slot1 = s1List[i];
		slot2 = s2List[i];
	endtask

	// the idle cycle, all three slots have had their turn
	task automatic checkLine(input int i);
		assert (retAddr == expList[i]) else begin
			$display("FAIL @%0t ns: line %0d retAddr %h, expected %h", $time,
				lineList[i], retAddr, expList[i]);
			$display("RESULT: FAIL");
			$fatal(1, "retAddr mismatch");
		end
	endtask

	initial begin
		rst = 1'b1;
		bundleIp = '0;
		slot0 = '0;
		slot1 = '0;
		slot2 = '0;
		loadTests();
		loaded = 1'b1;
		repeat (10) @(posedge clk4x);
		// release on a falling edge, the cycle that follows is slot 0
		@(negedge clk4x);
		rst = 1'b0;
		for (int i = 0; i < nLines; i++) begin
			applyLine(i);
			repeat (3) @(negedge clk4x);
			checkLine(i);
			@(negedge clk4x);
		end
		if (nLines > 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("the test data file held no bundles to check");
			$display("RESULT: FAIL");
			$fatal(1, "nothing checked");
		end
	end

	// sixteen ns per bundle plus room for reset
	initial begin
		wait (loaded);
		#(nLines * 16 + 200);
		$display("timeout: the bundles were not all checked in the expected time");
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- design/bundleDecode.sv
// ======================================================================
// combinational slot decoder, no latency
// bundleIp must have its low 4 bits clear, other values give
// meaningless link addresses
// ======================================================================

module bundleDecode import rasPkg::*; (
	input addrT bundleIp,
	input slotInT slot0,
	input slotInT slot1,
	input slotInT slot2,
	output slotOpT op0,
	output slotOpT op1,
	output slotOpT op2
);

	// ==================================================================
	// per-slot classification
	// ==================================================================

	// a call wins over a return when a slot looks like both
	// (jal that writes and reads the link register counts as a push)
	function automatic slotOpT decodeSlot(input slotInT s, input addrT link);
		slotOpT r;
		logic jalCall;
		logic jalRet;
		jalCall = s.jal && (s.rd == LinkReg);
		jalRet = s.jal && (s.ra == LinkReg);
		r.queued = s.queued;
		r.isPush = s.call || jalCall;
		r.isPop = !r.isPush && (s.ret || jalRet);
		r.seqNum = s.seqNum;
		r.linkAddr = link;
		return r;
	endfunction

	// ==================================================================
	// link addresses
	// ==================================================================

	// the return lands on the slot after the call
	addrT link0;
	addrT link1;
	addrT link2;

	assign link0 = bundleIp + LinkOff0;
	assign link1 = bundleIp + LinkOff1;
	// slot 2 falls through into the next bundle
	assign link2 = bundleIp + LinkOff2;

	// ==================================================================
	// outputs
	// ==================================================================

	assign op0 = decodeSlot(slot0, link0);
	assign op1 = decodeSlot(slot1, link1);
	assign op2 = decodeSlot(slot2, link2);

	// ==================================================================
	// checks
	// ==================================================================

	// the control block relies on each slot asking for one stack action
	// only, whatever combination of call, ret and jal arrives
	always_comb begin
		assert (!(op0.isPush && op0.isPop) && !(op1.isPush && op1.isPop)
			&& !(op2.isPush && op2.isPop))
		else $error("slot decoded as both push and pop");
	end

endmodule

//--- design/rasControl.sv
// ======================================================================
// bundle sequencer and stack command issue
// inputs must be held steady for the four clk4x cycles of a bundle
// only the first slot of a bundle that touches the stack may act, and a
// slot repeated with the same sequence number is ignored
// ======================================================================

module rasControl import rasPkg::*; (
	input logic clk4x,
	input logic rst,
	input slotOpT op0,
	input slotOpT op1,
	input slotOpT op2,
	output stackCmdT cmd
);

	// ==================================================================
	// state
	// ==================================================================

	// phase k handles slot k, the fourth cycle is left idle
	phaseT phase;
	logic [1:0] slotIdx;

	// per slot, whether anything has been accepted and its sequence number
	logic [2:0] accepted;
	seqNumT lastSeq [3];

	// ==================================================================
	// slot selection
	// ==================================================================

	// modifying means queued and asking for a push or a pop
	logic mod0;
	logic mod1;
	logic mod2;
	slotOpT selOp;
	logic selMod;
	logic lowerMod;
	logic seenBefore;
	logic issue;

	assign mod0 = op0.queued && (op0.isPush || op0.isPop);
	assign mod1 = op1.queued && (op1.isPush || op1.isPop);
	assign mod2 = op2.queued && (op2.isPush || op2.isPop);

	assign slotIdx = phase;

	// a lower modifying slot blocks the higher ones even when that
	// lower slot was itself dropped as a repeat
	always_comb begin
		case (phase)
			PhSlot0: begin
				selOp = op0;
				selMod = mod0;
				lowerMod = 1'b0;
				seenBefore = accepted[0] && (lastSeq[0] == op0.seqNum);
			end
			PhSlot1: begin
				selOp = op1;
				selMod = mod1;
				lowerMod = mod0;
				seenBefore = accepted[1] && (lastSeq[1] == op1.seqNum);
			end
			PhSlot2: begin
				selOp = op2;
				selMod = mod2;
				lowerMod = mod0 || mod1;
				seenBefore = accepted[2] && (lastSeq[2] == op2.seqNum);
			end
			default: begin
				// idle cycle, nothing is issued
				selOp = '0;
				selMod = 1'b0;
				lowerMod = 1'b1;
				seenBefore = 1'b0;
			end
		endcase
	end

	// no commands while reset is held
	assign issue = !rst && selMod && !lowerMod && !seenBefore;

	// ==================================================================
	// command out
	// ==================================================================

	// decode never sets both flags, so at most one of push and pop is set
	assign cmd.push = issue && selOp.isPush;
	assign cmd.pop = issue && selOp.isPop;
	assign cmd.data = selOp.linkAddr;

	// ==================================================================
	// sequencing and the repeat filter
	// ==================================================================

	always_ff @(posedge clk4x) begin
		if (rst) begin
			phase <= PhSlot0;
			accepted <= '0;
		end else begin
			// PhIdle wraps back to PhSlot0
			phase <= phaseT'(phase + 2'd1);
			if (issue) begin
				accepted[slotIdx] <= 1'b1;
			end
		end
	end

	// sequence numbers only count once the matching accepted flag is set
	always_ff @(posedge clk4x) begin
		if (issue) begin
			lastSeq[slotIdx] <= selOp.seqNum;
		end
	end

	// ==================================================================
	// checks
	// ==================================================================

	// the phase steps by one every cycle and never stalls
	a_phaseStep: assert property (
		@(posedge clk4x) disable iff (rst)
		!rst |=> (phase == phaseT'($past(phase) + 2'd1))
	) else $error("phase did not advance");

endmodule

//--- design/rasPkg.sv
// ======================================================================
// shared widths, constants and slot records for the return predictor
// addresses are 32 bits, and a bundle is 16 bytes holding three slots
// at byte offsets 0, 5 and 10
// ======================================================================

package rasPkg;

	// ==================================================================
	// widths and plain vector types
	// ==================================================================

	// instruction address width; the low 4 bits of a bundle address are zero
	localparam int AddrW = 32;
	typedef logic [AddrW-1:0] addrT;

	// stack geometry, the pointer wraps so the depth must be a power of two
	localparam int RasDepth = 16;
	localparam int RasPtrW = 4;
	typedef logic [RasPtrW-1:0] rasPtrT;

	// fetch queue sequence number and register number
	localparam int SeqW = 5;
	localparam int RegW = 6;
	typedef logic [SeqW-1:0] seqNumT;
	typedef logic [RegW-1:0] regNumT;

	// ==================================================================
	// constants
	// ==================================================================

	// jal writing this register is a call, jal reading it is a return
	localparam regNumT LinkReg = 6'd61;

	// every stack entry holds this value after reset
	localparam addrT ResetRetAddr = 32'hFFFF_FC00;

	// link address offsets from the bundle address, one per slot
	// slot 2 links to the first slot of the following bundle
	localparam addrT LinkOff0 = 32'd5;
	localparam addrT LinkOff1 = 32'd10;
	localparam addrT LinkOff2 = 32'd16;

	// ==================================================================
	// records
	// ==================================================================

	// one fetched slot as presented by the fetch queue
	typedef struct packed {
		logic queued;
		logic jal;
		logic call;
		logic ret;
		regNumT ra;
		regNumT rd;
		seqNumT seqNum;
	} slotInT;

	// decoded slot, isPush and isPop are never both set
	typedef struct packed {
		logic queued;
		logic isPush;
		logic isPop;
		seqNumT seqNum;
		addrT linkAddr;
	} slotOpT;

	// single-cycle command into the stack
	typedef struct packed {
		logic push;
		logic pop;
		addrT data;
	} stackCmdT;

	// clk4x cycles within one bundle period
	typedef enum logic [1:0] {
		PhSlot0 = 2'd0,
		PhSlot1 = 2'd1,
		PhSlot2 = 2'd2,
		PhIdle = 2'd3
	} phaseT;

endpackage

//--- design/retPredictTop.sv
// ======================================================================
// return address predictor top level
// all inputs are level signals held for one bundle period of four clk4x
// cycles, and retAddr reflects the whole bundle by the idle cycle
// ======================================================================

module retPredictTop import rasPkg::*; (
	input logic clk4x,
	input logic rst,
	input addrT bundleIp,
	input slotInT slot0,
	input slotInT slot1,
	input slotInT slot2,
	output addrT retAddr
);

	// decoded slots and the stack command
	slotOpT op0;
	slotOpT op1;
	slotOpT op2;
	stackCmdT cmd;

	// ==================================================================
	// decode, issue and storage
	// ==================================================================

	bundleDecode u_decode (
		.bundleIp(bundleIp),
		.slot0(slot0),
		.slot1(slot1),
		.slot2(slot2),
		.op0(op0),
		.op1(op1),
		.op2(op2)
	);

	// one slot per clk4x cycle, so each bundle can move the stack once
	rasControl u_control (
		.clk4x(clk4x),
		.rst(rst),
		.op0(op0),
		.op1(op1),
		.op2(op2),
		.cmd(cmd)
	);

	returnStack u_stack (
		.clk4x(clk4x),
		.rst(rst),
		.cmd(cmd),
		.retAddr(retAddr)
	);

endmodule

//--- design/returnStack.sv
// ======================================================================
// circular return address stack, 16 entries
// overflow silently overwrites the oldest entry and underflow wraps
// push and pop in the same cycle are not supported
// ======================================================================

module returnStack import rasPkg::*; (
	input logic clk4x,
	input logic rst,
	input stackCmdT cmd,
	output addrT retAddr
);

	// ==================================================================
	// storage
	// ==================================================================

	// entries are addressed relative to the pointer, which names the top
	addrT stack [RasDepth];
	rasPtrT ptr;

	// slot just above the top, where the next push lands
	rasPtrT pushPtr;

	// the stack grows downwards, so a push steps the pointer back by one
	assign pushPtr = rasPtrT'(ptr - 1'b1);

	// ==================================================================
	// update
	// ==================================================================

	// reset has to refill the entries too, so that popping past the
	// bottom after reset still returns a known address
	always_ff @(posedge clk4x) begin
		if (rst) begin
			for (int i = 0; i < RasDepth; i++) begin
				stack[i] <= ResetRetAddr;
			end
			ptr <= '0;
		end else begin
			if (cmd.push) begin
				// the oldest entry is lost here once all 16 are in use
				stack[pushPtr] <= cmd.data;
				ptr <= pushPtr;
			end else if (cmd.pop) begin
				// nothing is cleared on a pop, the entry just falls below the top
				ptr <= rasPtrT'(ptr + 1'b1);
			end
		end
	end

	// ==================================================================
	// prediction
	// ==================================================================

	// the top of the stack is always the predicted return address
	assign retAddr = stack[ptr];

	// ==================================================================
	// checks
	// ==================================================================

	// the control block issues at most one action per clk4x cycle
	a_onePerCycle: assert property (
		@(posedge clk4x) disable iff (rst)
		!(cmd.push && cmd.pop)
	) else $error("push and pop issued together");

endmodule

//--- list.f
design/rasPkg.sv
design/bundleDecode.sv
design/returnStack.sv
design/rasControl.sv
design/retPredictTop.sv
bench/retPredictTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# builds the return address predictor testbench with Verilator and runs it
# the result is taken from the simulation log

set -u

cd "$(dirname "$0")" || exit 1

buildDir=build
logFile=sim.log

if ! verilator --binary --timing --assert -f list.f \
	--top-module retPredictTb -Mdir "$buildDir" -o simv; then
	echo "verilator build failed"
	exit 1
fi

"./$buildDir/simv" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q -x "RESULT: FAIL" "$logFile"; then
	echo "simulation reported a failure"
	exit 1
fi

if [ "$simStatus" -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if ! grep -q -x "RESULT: PASS" "$logFile"; then
	echo "simulation ended without a result line"
	exit 1
fi

echo "simulation passed"
exit 0
